/* Makefile */
VERILATOR ?= verilator
TOP       ?= afc_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= ** PASS **

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/afc_tb.sv */
// run from the project root; aac stable codes stay at 1 or above so the detector settles
`timescale 1ns/1ps
`default_nettype none

module afc_tb;
    import afc_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int n_fields     = 14;
    localparam int max_tests    = 32;

    logic               clk_gated;
    logic               rstn;
    logic               afc_en;
    logic               trx;
    logic [divr_w-1:0]  divr;
    logic               rg_forceband_en;
    logic [band_w-1:0]  rg_vco_capband;
    logic [1:0]         rg_afc_vcostable_time;
    logic [win_w-1:0]   rg_afc_cnt_time;
    logic [ncnt_w-1:0]  a2d_afc_ncntr = '0;
    logic               rg_aac_bypass;
    logic [1:0]         rg_aac_stable_time;
    logic [ibvco_w-1:0] rg_ini_ibsel_rx;
    logic [ibvco_w-1:0] rg_ini_ibsel_tx;
    logic               a2d_aac_pkd_state = 1'b1;
    logic               afc_openloop_en;
    logic [band_w-1:0]  afc_vco_capband;
    logic               afc_cntr_rstn;
    logic               afc_cntr_en;
    logic               afc_cntr_datasyn;
    logic [ibvco_w-1:0] afc_ibvco;
    logic [ncnt_w-1:0]  afc_minerr;
    logic               afc_finish;

    int          vco_off = 0;
    int          vco_slope = 0;
    int          pk_level = 0;
    int          seed = 52660;
    int          n_tests = 0;
    // running totals kept by the strobe monitor
    int          rst_pulses = 0;
    int          syn_pulses = 0;
    int          en_windows = 0;
    int          en_len = 0;
    int          ol_rises = 0;
    logic        prev_rstn = 1'b1;
    logic        prev_syn = 1'b0;
    logic        prev_en = 1'b0;
    logic        prev_ol = 1'b0;
    logic        prev_fin = 1'b0;
    logic [31:0] test_mem [0:n_fields*max_tests-1];

    afc_top u_afc_top (.*);

    initial begin
        clk_gated = 1'b0;
        forever #(clk_period / 2) clk_gated = ~clk_gated;
    end

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    // count falls as the band rises
    function automatic logic [ncnt_w-1:0] vco_count(input logic [band_w-1:0] band);
        int c;
        c = vco_off - vco_slope * int'(band);
        return c[ncnt_w-1:0];
    endfunction

    // seven-step bit search, first strict minimum of the error wins
    function automatic void search_model(input int tgt, output int band, output int err);
        int cur;
        int cnt;
        int e;
        cur  = 0;
        band = 'h40;
        err  = 'h3fff;
        for (int s = 0; s < 7; s++) begin
            cur = cur | (1 << (6 - s));
            cnt = int'(vco_count(7'(cur)));
            e   = (cnt >= tgt) ? cnt - tgt : tgt - cnt;
            if (e < err) begin
                err  = e;
                band = cur;
            end
            if (cnt < tgt) cur = cur & ~(1 << (6 - s));
        end
    endfunction

    // ------------------------------------------------------------------------
    // vco counter and peak detector models
    // ------------------------------------------------------------------------
    always @(posedge clk_gated) begin
        a2d_afc_ncntr     <= vco_count(afc_vco_capband);
        a2d_aac_pkd_state <= (int'(afc_ibvco) <= pk_level);
    end

    // strobe monitor, sampled away from the active edge
    always @(negedge clk_gated) begin
        if (rstn) begin
            if (prev_rstn && !afc_cntr_rstn) rst_pulses = rst_pulses + 1;
            if (!prev_syn && afc_cntr_datasyn) syn_pulses = syn_pulses + 1;
            if (afc_cntr_en) begin
                en_len = en_len + 1;
            end else if (prev_en) begin
                en_windows = en_windows + 1;
                expect_equal("afc_cntr_en window", 32'(en_len), 32'(rg_afc_cnt_time) + 32'd1);
                en_len = 0;
            end
            if (afc_openloop_en && !prev_ol) ol_rises = ol_rises + 1;
            // open loop may only end together with finish
            if (!afc_openloop_en && prev_ol) begin
                expect_equal("afc_finish at afc_openloop_en fall", 32'(afc_finish), 32'd1);
            end
            // finish only clears after a new afc_en rise or under force
            if (!afc_finish && prev_fin) begin
                expect_equal("afc_en or force at afc_finish fall",
                             32'(afc_en | rg_forceband_en), 32'd1);
            end
        end
        prev_rstn = afc_cntr_rstn;
        prev_syn  = afc_cntr_datasyn;
        prev_en   = afc_cntr_en;
        prev_ol   = afc_openloop_en;
        prev_fin  = afc_finish;
    end

    initial begin
        wait (n_tests > 0);
        repeat (n_tests * 2000) @(posedge clk_gated);
        abort_run("timeout, the calibrations did not complete in time");
    end

    // ------------------------------------------------------------------------
    // file-driven test sequence
    // ------------------------------------------------------------------------
    initial begin
        int   base;
        int   gap;
        int   cnt;
        int   tgt;
        int   t_band;
        int   t_err;
        int   t_cur;
        int   rst0;
        int   syn0;
        int   win0;
        int   ol0;
        logic prev_calib;
        rstn                  <= 1'b0;
        afc_en                <= 1'b0;
        trx                   <= 1'b0;
        divr                  <= '0;
        rg_forceband_en       <= 1'b0;
        rg_vco_capband        <= '0;
        rg_afc_vcostable_time <= 2'd1;
        rg_afc_cnt_time       <= 7'd1;
        rg_aac_bypass         <= 1'b1;
        rg_aac_stable_time    <= 2'd1;
        rg_ini_ibsel_rx       <= '0;
        rg_ini_ibsel_tx       <= '0;
        prev_calib = 1'b0;
        for (int i = 0; i < n_fields * max_tests; i++) test_mem[i] = 32'hdead_0000 | 32'(i);
        $readmemh("bench/afc_tests.txt", test_mem);
        cnt = 0;
        while (cnt < max_tests && test_mem[cnt * n_fields] <= 32'd1) cnt = cnt + 1;
        if (cnt == 0) abort_run("no tests found in bench/afc_tests.txt");
        n_tests = cnt;
        repeat (reset_cycles) @(posedge clk_gated);
        rstn <= 1'b1;

        for (int t = 0; t < n_tests; t++) begin
            base = t * n_fields;
            @(posedge clk_gated);
            divr                  <= test_mem[base+1][divr_w-1:0];
            rg_afc_cnt_time       <= test_mem[base+2][win_w-1:0];
            vco_off               <= int'(test_mem[base+3]);
            vco_slope             <= int'(test_mem[base+4]);
            pk_level              <= int'(test_mem[base+5]);
            rg_ini_ibsel_rx       <= test_mem[base+6][ibvco_w-1:0];
            rg_ini_ibsel_tx       <= test_mem[base+7][ibvco_w-1:0];
            trx                   <= test_mem[base+8][0];
            rg_aac_bypass         <= test_mem[base+9][0];
            rg_vco_capband        <= test_mem[base+10][band_w-1:0];
            rg_afc_vcostable_time <= 2'(t % 4);
            rg_aac_stable_time    <= 2'(1 + t % 3);
            gap = 4 + ($random(seed) & 15);
            repeat (gap) @(posedge clk_gated);
            rst0 = rst_pulses;
            syn0 = syn_pulses;
            win0 = en_windows;
            ol0  = ol_rises;
            if (test_mem[base] == 32'd0) begin
                @(negedge clk_gated);
                if (prev_calib) expect_equal("afc_finish before afc_en", 32'(afc_finish), 32'd1);
                @(posedge clk_gated);
                afc_en <= 1'b1;
                @(negedge clk_gated);
                while (afc_finish) @(negedge clk_gated);
                while (!afc_finish) @(negedge clk_gated);
                tgt = (int'(divr) * int'(rg_afc_cnt_time) + 128) / 256;
                search_model(tgt, t_band, t_err);
                t_cur = trx ? int'(rg_ini_ibsel_tx) : int'(rg_ini_ibsel_rx);
                if (!rg_aac_bypass) begin
                    if (pk_level < t_cur) t_cur = pk_level;
                    t_cur = (t_cur >= 15) ? 15 : t_cur + 1;
                end
                expect_equal("target", 32'(u_afc_top.target), 32'(tgt));
                expect_equal("afc_vco_capband", 32'(afc_vco_capband), 32'(t_band));
                expect_equal("afc_minerr", 32'(afc_minerr), 32'(t_err));
                expect_equal("afc_ibvco", 32'(afc_ibvco), 32'(t_cur));
                expect_equal("model band vs file", 32'(t_band), test_mem[base+11]);
                expect_equal("model minerr vs file", 32'(t_err), test_mem[base+12]);
                expect_equal("model ibvco vs file", 32'(t_cur), test_mem[base+13]);
                expect_equal("afc_cntr_rstn low pulses", 32'(rst_pulses - rst0), 32'd7);
                expect_equal("afc_cntr_datasyn pulses", 32'(syn_pulses - syn0), 32'd7);
                expect_equal("afc_cntr_en windows", 32'(en_windows - win0), 32'd7);
                expect_equal("afc_openloop_en rises", 32'(ol_rises - ol0), 32'd1);
                @(posedge clk_gated);
                afc_en <= 1'b0;
                prev_calib = 1'b1;
            end else begin
                // force band holds the register band, an afc_en rise must not start
                rg_forceband_en <= 1'b1;
                repeat (4) @(posedge clk_gated);
                afc_en <= 1'b1;
                repeat (32) begin
                    @(negedge clk_gated);
                    expect_equal("afc_finish", 32'(afc_finish), 32'd0);
                    expect_equal("afc_openloop_en", 32'(afc_openloop_en), 32'd0);
                    expect_equal("afc_cntr_en", 32'(afc_cntr_en), 32'd0);
                end
                expect_equal("afc_vco_capband", 32'(afc_vco_capband), 32'(rg_vco_capband));
                expect_equal("afc_minerr", 32'(afc_minerr), 32'h1555);
                expect_equal("afc_ibvco", 32'(afc_ibvco), test_mem[base+13]);
                expect_equal("force band vs file", 32'(rg_vco_capband), test_mem[base+11]);
                expect_equal("force minerr vs file", 32'h1555, test_mem[base+12]);
                expect_equal("afc_cntr_rstn low pulses", 32'(rst_pulses - rst0), 32'd0);
                @(posedge clk_gated);
                afc_en          <= 1'b0;
                rg_forceband_en <= 1'b0;
                prev_calib = 1'b0;
            end
        end

        @(negedge clk_gated);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/afc_tests.txt */
// mode divr win vco_off vco_slope peak ini_rx ini_tx trx bypass fband | band minerr ibvco
// all hex; mode 0 runs a calibration, mode 1 holds force band
0 0800 20 0400 08 7 5 9 0 1 00 60 0000 5
0 1234 2b 0c00 14 9 3 6 1 0 00 72 0009 7
0 0a00 10 0080 01 4 c 2 0 0 00 01 0021 5
0 0100 05 2000 10 f 1 f 1 0 00 7f 180b f
1 0100 05 2000 10 f 1 f 1 0 2a 2a 1555 f
0 0380 3b 1000 20 3 0 8 0 0 00 7a 000f 1
0 0304 64 0200 04 0 2 a 1 1 00 34 0002 a
0 ffff 3f 3fff 40 2 4 9 1 0 00 04 0001 3
1 ffff 3f 3fff 40 2 4 9 1 0 55 55 1555 3
0 4000 01 0100 01 7 7 1 0 0 00 7f 0041 8

/* design/aac_current.sv */
// trx and the initial current codes are sampled only at aac_load
`timescale 1ns/1ps
`default_nettype none

module aac_current (
    input  logic                        clk_gated,
    input  logic                        rstn,
    input  logic                        aac_load,
    input  logic                        aac_step,
    input  logic                        pkd_sync,
    input  logic                        trx,
    input  logic [afc_pkg::ibvco_w-1:0] rg_ini_ibsel_rx,
    input  logic [afc_pkg::ibvco_w-1:0] rg_ini_ibsel_tx,
    output logic [afc_pkg::ibvco_w-1:0] afc_ibvco,
    output logic                        ibvco_zero
);
    import afc_pkg::*;

    // detector high means the swing is low, so raise the bias
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) afc_ibvco <= '0;
        else if (aac_load) afc_ibvco <= trx ? rg_ini_ibsel_tx : rg_ini_ibsel_rx;
        else if (aac_step && pkd_sync && !(&afc_ibvco)) afc_ibvco <= afc_ibvco + 1'b1;
        else if (aac_step && !pkd_sync && !ibvco_zero) afc_ibvco <= afc_ibvco - 1'b1;
    end

    assign ibvco_zero = (afc_ibvco == '0);

    // moves only on a step, by one code at most and without wrapping
    a_single_step: assert property (@(posedge clk_gated) disable iff (!rstn)
        !aac_load |=> ($past(aac_step) || $stable(afc_ibvco)) &&
            (int'(afc_ibvco) - int'($past(afc_ibvco)) <= 1) &&
            (int'($past(afc_ibvco)) - int'(afc_ibvco) <= 1));

endmodule

`default_nettype wire

/* design/afc_band_search.sv */
// a2d_afc_ncntr is taken as stable at the bit_decide strobe, no resync here
`timescale 1ns/1ps
`default_nettype none

module afc_band_search (
    input  logic                       clk_gated,
    input  logic                       rstn,
    input  logic                       force_en,
    input  logic [afc_pkg::band_w-1:0] rg_vco_capband,
    input  logic [afc_pkg::ncnt_w-1:0] a2d_afc_ncntr,
    input  logic [afc_pkg::ncnt_w-1:0] target,
    afc_step_if.search                 step,
    input  logic                       done,
    output logic [afc_pkg::band_w-1:0] afc_vco_capband,
    output logic [afc_pkg::ncnt_w-1:0] afc_minerr
);
    import afc_pkg::*;

    logic [ncnt_w:0]   diff;
    logic [ncnt_w-1:0] err_abs;
    logic [ncnt_w-1:0] best_err;
    logic [band_w-1:0] best_band;
    logic [2:0]        bit_pos;

    // signed error; a full-scale negative value saturates
    assign diff    = {1'b0, a2d_afc_ncntr} - {1'b0, target};
    assign err_abs = !diff[ncnt_w] ? diff[ncnt_w-1:0] :
                     (diff[ncnt_w-1:0] == '0) ? err_max : -diff[ncnt_w-1:0];
    assign bit_pos = 3'd6 - step.step_idx;

    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            afc_vco_capband <= band_mid;
            best_band       <= band_mid;
            best_err        <= err_max;
            afc_minerr      <= '0;
        end else if (force_en) begin
            afc_vco_capband <= rg_vco_capband;
            afc_minerr      <= force_minerr;
        end else begin
            if (step.search_init) begin
                afc_vco_capband <= '0;
                best_band       <= band_mid;
                best_err        <= err_max;
            end else if (step.bit_set) begin
                afc_vco_capband[bit_pos] <= 1'b1;
            end else if (step.bit_decide) begin
                // count below target means the band is too high
                if (diff[ncnt_w]) afc_vco_capband[bit_pos] <= 1'b0;
                if (err_abs < best_err) begin
                    best_err  <= err_abs;
                    best_band <= afc_vco_capband;
                end
            end else if (step.load_opt) begin
                afc_vco_capband <= best_band;
            end
            if (done) afc_minerr <= best_err;
        end
    end

    // measured band still holds the bit under test and nothing below it
    a_band_hold: assert property (@(posedge clk_gated) disable iff (!rstn || force_en)
        step.bit_decide |-> afc_vco_capband[bit_pos] &&
            ((afc_vco_capband & ((band_w'(1) << bit_pos) - band_w'(1))) == '0));

endmodule

`default_nettype wire

/* design/afc_pkg.sv */
// widths and encodings for the afc core; wait codes above 3 are not defined
`default_nettype none

package afc_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int band_w  = 7;
    localparam int ncnt_w  = 14;
    localparam int divr_w  = 16;
    localparam int win_w   = 7;
    localparam int ibvco_w = 4;

    // reset and override values
    localparam logic [band_w-1:0] band_mid     = 7'h40;
    localparam logic [ncnt_w-1:0] err_max      = 14'h3fff;
    localparam logic [ncnt_w-1:0] force_minerr = 14'h1555;

    typedef enum logic [4:0] {
        idle, band_init, wait_vco, cntr_rst, cntr_pre, cntr_run, cntr_post,
        cntr_sync, band_update, set_opt, wait_opt, aac_start, aac_dly2,
        aac_settle, aac_update, aac_end, done
    } afc_state_e;

    // stable-time code to wait length minus one (2, 4, 8, 16 cycles)
    function automatic logic [3:0] stable_m1(input logic [1:0] code);
        case (code)
            2'd0:    return 4'd1;
            2'd1:    return 4'd3;
            2'd2:    return 4'd7;
            default: return 4'd15;
        endcase
    endfunction

endpackage

`default_nettype wire

/* design/afc_sequencer.sv */
// counter timing assumes the analog counter is ready whenever it is sampled
`timescale 1ns/1ps
`default_nettype none

module afc_sequencer (
    input  logic                      clk_gated,
    input  logic                      rstn,
    input  logic                      start,
    input  logic                      pkd_sync,
    input  logic                      ibvco_zero,
    input  logic                      rg_aac_bypass,
    input  logic [1:0]                rg_afc_vcostable_time,
    input  logic [1:0]                rg_aac_stable_time,
    input  logic [afc_pkg::win_w-1:0] rg_afc_cnt_time,
    afc_step_if.seq                   step,
    output logic                      aac_step,
    output logic                      aac_load,
    output logic                      busy,
    output logic                      done,
    output logic                      afc_cntr_rstn,
    output logic                      afc_cntr_en,
    output logic                      afc_cntr_datasyn
);
    import afc_pkg::*;

    afc_state_e       state;
    afc_state_e       state_next;
    logic [win_w-1:0] tmr;
    logic [2:0]       loop_cnt;
    logic             vco_end;
    logic             aac_wait_end;

    assign vco_end      = (tmr == win_w'(stable_m1(rg_afc_vcostable_time)));
    assign aac_wait_end = (tmr == win_w'(stable_m1(rg_aac_stable_time)));

    // ------------------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            idle:        if (start) state_next = band_init;
            band_init:   state_next = wait_vco;
            wait_vco:    if (vco_end) state_next = cntr_rst;
            cntr_rst:    state_next = cntr_pre;
            cntr_pre:    state_next = cntr_run;
            cntr_run:    if (tmr == rg_afc_cnt_time) state_next = cntr_post;
            cntr_post:   state_next = cntr_sync;
            cntr_sync:   state_next = band_update;
            band_update: state_next = (loop_cnt == 3'd6) ? set_opt : band_init;
            set_opt:     state_next = wait_opt;
            wait_opt: begin
                if (vco_end) state_next = rg_aac_bypass ? afc_pkg::done : aac_start;
            end
            aac_start:   state_next = aac_dly2;
            aac_dly2:    if (tmr == win_w'(1)) state_next = aac_settle;
            aac_settle:  if (aac_wait_end) state_next = aac_update;
            // stop once the detector trips or the current bottoms out
            aac_update:  state_next = (pkd_sync || ibvco_zero) ? aac_end : aac_settle;
            aac_end:     if (aac_wait_end) state_next = afc_pkg::done;
            default:     state_next = idle;
        endcase
    end

    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) state <= idle;
        else state <= state_next;
    end

    // shared wait timer, restarts on every state change
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) tmr <= '0;
        else if (state_next != state) tmr <= '0;
        else tmr <= tmr + win_w'(1);
    end

    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) loop_cnt <= '0;
        else if (state == idle && start) loop_cnt <= '0;
        else if (state == band_update) loop_cnt <= loop_cnt + 3'd1;
    end

    // ------------------------------------------------------------------------
    // external counter controls
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            afc_cntr_rstn    <= 1'b1;
            afc_cntr_en      <= 1'b0;
            afc_cntr_datasyn <= 1'b0;
        end else begin
            afc_cntr_rstn    <= !(state == wait_vco && vco_end);
            afc_cntr_datasyn <= (state == cntr_post);
            if (state == cntr_pre) afc_cntr_en <= 1'b1;
            else if (state == cntr_run && state_next != cntr_run) afc_cntr_en <= 1'b0;
        end
    end

    // search strobes
    assign step.search_init = (state == idle) && start;
    assign step.bit_set     = (state == band_init);
    assign step.bit_decide  = (state == band_update);
    assign step.load_opt    = (state == set_opt);
    assign step.step_idx    = loop_cnt;

    assign aac_step = (state == aac_update);
    assign aac_load = start;
    assign busy     = (state != idle);
    assign done     = (state == afc_pkg::done);

    a_en_out_of_rst: assert property (@(posedge clk_gated) disable iff (!rstn)
        afc_cntr_en |-> afc_cntr_rstn);
    a_datasyn_pulse: assert property (@(posedge clk_gated) disable iff (!rstn)
        afc_cntr_datasyn |=> !afc_cntr_datasyn);

endmodule

`default_nettype wire

/* design/afc_step_if.sv */
// search strobes are single-cycle; step_idx is valid with every strobe
`timescale 1ns/1ps
`default_nettype none

interface afc_step_if;

    logic       search_init;
    logic       bit_set;
    logic       bit_decide;
    logic       load_opt;
    // step 0 works on band bit 6
    logic [2:0] step_idx;

    modport seq (
        output search_init, bit_set, bit_decide, load_opt, step_idx
    );

    modport search (
        input  search_init, bit_set, bit_decide, load_opt, step_idx
    );

endinterface

`default_nettype wire

/* design/afc_sync.sv */
// afc_en and force are async levels; start trails the afc_en rise by 4 to 5 cycles
`timescale 1ns/1ps
`default_nettype none

module afc_sync (
    input  logic clk_gated,
    input  logic rstn,
    input  logic afc_en,
    input  logic rg_forceband_en,
    input  logic a2d_aac_pkd_state,
    input  logic busy,
    output logic start,
    output logic force_en,
    output logic pkd_sync
);

    logic [2:0] en_sr;
    logic [1:0] force_sr;
    logic [1:0] pkd_sr;
    logic [1:0] pos_dly;

    // ------------------------------------------------------------------------
    // control synchronizers and enable edge
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            en_sr    <= '0;
            force_sr <= '0;
            pos_dly  <= '0;
        end else begin
            en_sr    <= {en_sr[1:0], afc_en};
            force_sr <= {force_sr[0], rg_forceband_en};
            pos_dly  <= {pos_dly[0], en_sr[1] & ~en_sr[2]};
        end
    end

    // peak detector only tracked during a calibration
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) pkd_sr <= 2'b11;
        else if (busy) pkd_sr <= {pkd_sr[0], a2d_aac_pkd_state};
    end

    assign force_en = force_sr[1];
    assign start    = pos_dly[1] & ~force_sr[1];
    assign pkd_sync = pkd_sr[1];

endmodule

`default_nettype wire

/* design/afc_target.sv */
// divr and window must hold still for eight cycles after start
`timescale 1ns/1ps
`default_nettype none

module afc_target (
    input  logic                       clk_gated,
    input  logic                       rstn,
    input  logic                       start,
    input  logic [afc_pkg::divr_w-1:0] divr,
    input  logic [afc_pkg::win_w-1:0]  rg_afc_cnt_time,
    output logic [afc_pkg::ncnt_w-1:0] target
);
    import afc_pkg::*;

    logic                    busy;
    logic [2:0]              cnt;
    logic [divr_w+win_w-1:0] acc;
    logic [7:0]              win_ext;

    assign win_ext = {1'b0, rg_afc_cnt_time};

    // shift-add, one window bit per cycle, then round off the low byte
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            busy   <= 1'b0;
            cnt    <= '0;
            acc    <= '0;
            target <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
            acc  <= '0;
        end else if (busy) begin
            if (cnt == 3'd7) begin
                busy   <= 1'b0;
                target <= acc[ncnt_w+7:8] + ncnt_w'(acc[7]);
            end else begin
                cnt <= cnt + 3'd1;
                if (win_ext[cnt]) acc <= acc + ({{win_w{1'b0}}, divr} << cnt);
            end
        end
    end

    a_no_restart: assert property (@(posedge clk_gated) disable iff (!rstn)
        busy |-> !start);

endmodule

`default_nettype wire

/* design/afc_top.sv */
// runs on clk_gated only; a new afc_en rise during a calibration is not allowed
`timescale 1ns/1ps
`default_nettype none

module afc_top (
    input  logic                        rstn,
    input  logic                        clk_gated,
    input  logic                        afc_en,
    input  logic                        trx,
    input  logic [afc_pkg::divr_w-1:0]  divr,
    input  logic                        rg_forceband_en,
    input  logic [afc_pkg::band_w-1:0]  rg_vco_capband,
    input  logic [1:0]                  rg_afc_vcostable_time,
    input  logic [afc_pkg::win_w-1:0]   rg_afc_cnt_time,
    input  logic [afc_pkg::ncnt_w-1:0]  a2d_afc_ncntr,
    input  logic                        rg_aac_bypass,
    input  logic [1:0]                  rg_aac_stable_time,
    input  logic [afc_pkg::ibvco_w-1:0] rg_ini_ibsel_rx,
    input  logic [afc_pkg::ibvco_w-1:0] rg_ini_ibsel_tx,
    input  logic                        a2d_aac_pkd_state,
    output logic                        afc_openloop_en,
    output logic [afc_pkg::band_w-1:0]  afc_vco_capband,
    output logic                        afc_cntr_rstn,
    output logic                        afc_cntr_en,
    output logic                        afc_cntr_datasyn,
    output logic [afc_pkg::ibvco_w-1:0] afc_ibvco,
    output logic [afc_pkg::ncnt_w-1:0]  afc_minerr,
    output logic                        afc_finish
);
    import afc_pkg::*;

    logic              start, force_en, pkd_sync, busy, done;
    logic              aac_step, aac_load, ibvco_zero;
    logic [ncnt_w-1:0] target;

    afc_step_if u_step ();

    afc_sync u_sync (.clk_gated, .rstn, .afc_en, .rg_forceband_en, .a2d_aac_pkd_state,
                     .busy, .start, .force_en, .pkd_sync);

    afc_target u_target (.clk_gated, .rstn, .start, .divr, .rg_afc_cnt_time, .target);

    afc_sequencer u_seq (.clk_gated, .rstn, .start, .pkd_sync, .ibvco_zero,
                         .rg_aac_bypass, .rg_afc_vcostable_time, .rg_aac_stable_time,
                         .rg_afc_cnt_time, .step(u_step.seq), .aac_step, .aac_load,
                         .busy, .done, .afc_cntr_rstn, .afc_cntr_en, .afc_cntr_datasyn);

    afc_band_search u_search (.clk_gated, .rstn, .force_en, .rg_vco_capband,
                              .a2d_afc_ncntr, .target, .step(u_step.search), .done,
                              .afc_vco_capband, .afc_minerr);

    aac_current u_aac (.clk_gated, .rstn, .aac_load, .aac_step, .pkd_sync, .trx,
                       .rg_ini_ibsel_rx, .rg_ini_ibsel_tx, .afc_ibvco, .ibvco_zero);

    // ------------------------------------------------------------------------
    // status flags
    // ------------------------------------------------------------------------
    // open loop drops in the same cycle that finish rises
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) afc_openloop_en <= 1'b0;
        else afc_openloop_en <= busy && !done && !force_en;
    end

    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) afc_finish <= 1'b0;
        else if (force_en || start) afc_finish <= 1'b0;
        else if (done) afc_finish <= 1'b1;
    end

endmodule

`default_nettype wire

/* files.f */
design/afc_pkg.sv
design/afc_step_if.sv
design/afc_sync.sv
design/afc_target.sv
design/afc_sequencer.sv
design/afc_band_search.sv
design/aac_current.sv
design/afc_top.sv
bench/afc_tb.sv
